//--- logic/isaPkg.sv
package isaPkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction field widths
	////////////////////////////////////////////////////////////////////////////

	localparam int dataWidth = 16;	// Instruction word
	localparam int opWidth = 4;		// Opcode, bits 15:12
	localparam int opExWidth = 4;	// Extended opcode, bits 7:4
	localparam int regWidth = 4;
	localparam int immWidth = 8;
	localparam int psrWidth = 5;

	typedef logic [dataWidth-1:0] instWord;
	typedef logic [opWidth-1:0] opCode;
	typedef logic [opExWidth-1:0] extCode;
	typedef logic [regWidth-1:0] regAddr;
	typedef logic [immWidth-1:0] immVal;
	typedef logic [psrWidth-1:0] psrWord;
	typedef logic [3:0] condCode;

	localparam regAddr linkReg = 4'd15;	// JAL return address register

	////////////////////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////////////////////

	localparam opCode opRtype = 4'b0000;	// Register ALU group, ext selects op
	localparam opCode opAndi = 4'b0001;
	localparam opCode opOri = 4'b0010;
	localparam opCode opXori = 4'b0011;
	localparam opCode opOtype = 4'b0100;	// Memory, jump and scond group
	localparam opCode opAddi = 4'b0101;
	localparam opCode opAddui = 4'b0110;
	localparam opCode opSubi = 4'b1001;
	localparam opCode opCmpi = 4'b1011;
	localparam opCode opBcond = 4'b1100;
	localparam opCode opMovi = 4'b1101;
	localparam opCode opLui = 4'b1111;

	// Register group extensions
	localparam extCode extAnd = 4'b0001;
	localparam extCode extOr = 4'b0010;
	localparam extCode extXor = 4'b0011;
	localparam extCode extAdd = 4'b0101;
	localparam extCode extAddu = 4'b0110;
	localparam extCode extSub = 4'b1001;
	localparam extCode extCmp = 4'b1011;
	localparam extCode extMov = 4'b1101;

	// Other group extensions
	localparam extCode extLoad = 4'b0000;
	localparam extCode extStor = 4'b0100;
	localparam extCode extJal = 4'b1000;
	localparam extCode extJcond = 4'b1100;
	localparam extCode extScond = 4'b1101;

	////////////////////////////////////////////////////////////////////////////
	// Condition codes and status bits
	////////////////////////////////////////////////////////////////////////////

	localparam condCode EQ = 4'b0000;
	localparam condCode NE = 4'b0001;
	localparam condCode CS = 4'b0010;
	localparam condCode CC = 4'b0011;
	localparam condCode HI = 4'b0100;
	localparam condCode LS = 4'b0101;
	localparam condCode GT = 4'b0110;
	localparam condCode LE = 4'b0111;
	localparam condCode FS = 4'b1000;
	localparam condCode FC = 4'b1001;
	localparam condCode LO = 4'b1010;
	localparam condCode HS = 4'b1011;
	localparam condCode LT = 4'b1100;
	localparam condCode GE = 4'b1101;
	localparam condCode UC = 4'b1110;	// 4'b1111 is unused

	localparam int psrZ = 0;	// Zero
	localparam int psrC = 1;	// Carry
	localparam int psrL = 2;	// Unsigned lower
	localparam int psrN = 3;	// Signed negative
	localparam int psrF = 4;	// Overflow

endpackage

//--- logic/ctrlPkg.sv
package ctrlPkg;

	// ALU operation select
	typedef enum logic [3:0]
	{
		aluAdd = 4'd0,
		aluAddu = 4'd1,
		aluSub = 4'd2,	// Also used for compares
		aluAnd = 4'd3,
		aluOr = 4'd4,
		aluXor = 4'd5,
		aluMov = 4'd6,
		aluLui = 4'd7
	} aluOpT;

	// Register file writeback source
	typedef enum logic [1:0]
	{
		linkPc = 2'b00,		// JAL return address
		condResult = 2'b01,	// SCOND flag result
		aluResult = 2'b10,
		memData = 2'b11		// SRAM read data
	} wbSelT;

	// Two-state fetch/decode sequence
	typedef enum logic
	{
		fetch = 1'b0,
		decode = 1'b1
	} seqStateT;

endpackage

//--- logic/fetchSequencer.sv
module fetchSequencer
#(
	parameter int acntWidth = 3,
	parameter int videoSlots = 2
)
(
	input logic clk,
	input logic rst,
	input isaPkg::instWord instruction,
	input logic [acntWidth-1:0] acnt,
	output ctrlPkg::seqStateT state,
	output isaPkg::instWord inst
);

	import isaPkg::*;
	import ctrlPkg::*;

	logic cpuSlot;

	// Slots below videoSlots belong to the video fetch
	assign cpuSlot = (acnt >= videoSlots);

	////////////////////////////////////////////////////////////////////////////
	// Fetch/decode state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			state <= fetch;
		else if (cpuSlot)
		begin
			// Every instruction finishes in one decode cycle
			if (state == fetch)
				state <= decode;
			else
				state <= fetch;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Instruction latch
	////////////////////////////////////////////////////////////////////////////

	// Keeps sampling through a video hold, ROM data stays valid
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			inst <= '0;
		else if (state == fetch)
			inst <= instruction;
	end

endmodule

//--- logic/instDecoder.sv
module instDecoder
(
	input ctrlPkg::seqStateT state,
	input isaPkg::instWord inst,
	input logic condTrue,			// Selected condition holds
	output logic branch,
	output logic jump,
	output logic memAddrSel,		// Memory address from rSrc
	output logic immSel,			// ALU B operand from immOut
	output logic pcEn,
	output logic writeEn,
	output logic sramCe,			// Active low strobes
	output logic sramOe,
	output logic sramWe,
	output logic romCe,
	output logic romOe,
	output logic condResult,
	output ctrlPkg::wbSelT wbSel,
	output isaPkg::regAddr rDst,
	output isaPkg::regAddr rSrc,
	output isaPkg::immVal immOut,
	output ctrlPkg::aluOpT aluOp,
	output logic psrEn,
	output isaPkg::condCode condSel
);

	import isaPkg::*;
	import ctrlPkg::*;

	opCode opcode;
	extCode ext;
	regAddr dstField;
	regAddr srcField;
	immVal immField;
	logic isJcond;

	// Immediate form to ALU operation
	function automatic aluOpT immAluOp(input opCode op);
		case (op)
			opAddui: return aluAddu;
			opSubi, opCmpi: return aluSub;
			opAndi: return aluAnd;
			opOri: return aluOr;
			opXori: return aluXor;
			opMovi: return aluMov;
			opLui: return aluLui;
			default: return aluAdd;
		endcase
	endfunction

	// Register form extension to ALU operation
	function automatic aluOpT regAluOp(input extCode code);
		case (code)
			extAddu: return aluAddu;
			extSub, extCmp: return aluSub;
			extAnd: return aluAnd;
			extOr: return aluOr;
			extXor: return aluXor;
			extMov: return aluMov;
			default: return aluAdd;
		endcase
	endfunction

	assign opcode = inst[dataWidth-1 -: opWidth];
	assign dstField = inst[dataWidth-opWidth-1 -: regWidth];
	assign ext = inst[dataWidth-opWidth-regWidth-1 -: opExWidth];
	assign srcField = inst[regWidth-1:0];
	assign immField = inst[immWidth-1:0];

	// JCOND carries its condition in the destination field
	assign isJcond = (opcode == opOtype) && (ext == extJcond);
	assign condSel = isJcond ? dstField : srcField;

	always_comb
	begin
		branch = 1'b0;
		jump = 1'b0;
		memAddrSel = 1'b0;
		immSel = 1'b0;
		pcEn = 1'b0;
		writeEn = 1'b0;
		sramCe = 1'b1;
		sramOe = 1'b1;
		sramWe = 1'b1;
		romCe = 1'b1;
		romOe = 1'b1;
		condResult = 1'b0;
		wbSel = aluResult;
		rDst = '0;
		rSrc = '0;
		immOut = '0;
		aluOp = aluAdd;
		psrEn = 1'b0;

		if (state == fetch)
		begin
			romCe = 1'b0;	// Read next instruction
			romOe = 1'b0;
		end
		else
		begin
			case (opcode)
				opAddi, opAddui, opSubi, opCmpi, opAndi, opOri, opXori, opMovi, opLui:
				begin
					rDst = dstField;
					immOut = immField;
					immSel = 1'b1;
					aluOp = immAluOp(opcode);
					writeEn = (opcode != opCmpi);	// Compare only sets flags
					psrEn = 1'b1;
					pcEn = 1'b1;
				end
				opRtype:
				begin
					case (ext)
						extAdd, extAddu, extSub, extCmp, extAnd, extOr, extXor, extMov:
						begin
							rDst = dstField;
							rSrc = srcField;
							aluOp = regAluOp(ext);
							writeEn = (ext != extCmp);
							psrEn = 1'b1;
							pcEn = 1'b1;
						end
						default: ;
					endcase
				end
				opOtype:
				begin
					case (ext)
						extLoad:
						begin
							rDst = dstField;
							rSrc = srcField;	// Address register
							memAddrSel = 1'b1;
							writeEn = 1'b1;
							wbSel = memData;
							sramCe = 1'b0;
							sramOe = 1'b0;
							pcEn = 1'b1;
						end
						extStor:
						begin
							rDst = dstField;	// Data register
							rSrc = srcField;
							memAddrSel = 1'b1;
							sramCe = 1'b0;
							sramOe = 1'b0;
							sramWe = 1'b0;
							pcEn = 1'b1;
						end
						extScond:
						begin
							rDst = dstField;
							writeEn = 1'b1;
							wbSel = ctrlPkg::condResult;
							condResult = condTrue && (condSel != UC);
							pcEn = 1'b1;
						end
						extJcond:
						begin
							rSrc = srcField;	// Target address
							jump = condTrue;
							pcEn = 1'b1;
						end
						extJal:
						begin
							rDst = linkReg;
							rSrc = srcField;
							jump = 1'b1;
							writeEn = 1'b1;
							wbSel = linkPc;
							pcEn = 1'b1;
						end
						default: ;
					endcase
				end
				opBcond:
				begin
					immOut = immField;	// Signed displacement
					immSel = 1'b1;
					branch = condTrue && (condSel != UC);
					pcEn = 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

//--- logic/flagUnit.sv
module flagUnit
(
	input logic clk,
	input logic rst,
	input isaPkg::psrWord psrIn,
	input logic psrEn,			// Only raised in decode
	input isaPkg::condCode condSel,
	output logic condTrue
);

	import isaPkg::*;

	psrWord psr;

	////////////////////////////////////////////////////////////////////////////
	// Processor status latch
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			psr <= '0;
		else if (psrEn)
			psr <= psrIn;
	end

	////////////////////////////////////////////////////////////////////////////
	// Condition evaluation
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (condSel)
			EQ: condTrue = psr[psrZ];
			CS: condTrue = psr[psrC];
			HI: condTrue = psr[psrL];
			GT: condTrue = psr[psrN];
			FS: condTrue = psr[psrF];
			NE: condTrue = !psr[psrZ];
			CC: condTrue = !psr[psrC];
			LS: condTrue = !psr[psrL];
			LE: condTrue = !psr[psrN];
			FC: condTrue = !psr[psrF];
			HS: condTrue = psr[psrZ] || psr[psrL];
			GE: condTrue = psr[psrZ] || psr[psrN];
			LO: condTrue = !psr[psrZ] && !psr[psrL];	// Strictly lower
			LT: condTrue = !psr[psrZ] && !psr[psrN];
			UC: condTrue = 1'b1;
			default: condTrue = 1'b0;	// Unused encoding never holds
		endcase
	end

endmodule

//--- logic/cpuController.sv
module cpuController
#(
	parameter int acntWidth = 3,	// Arbiter slot counter width
	parameter int videoSlots = 2	// Leading slots owned by video
)
(
	input logic clk,
	input logic rst,
	input isaPkg::instWord instruction,	// From ROM
	input isaPkg::psrWord psrIn,		// From ALU
	input logic [acntWidth-1:0] acnt,
	output logic branch,
	output logic jump,
	output logic memAddrSel,
	output logic immSel,
	output logic pcEn,
	output logic writeEn,
	output logic sramCe,
	output logic sramOe,
	output logic sramWe,
	output logic romCe,
	output logic romOe,
	output logic condResult,
	output ctrlPkg::wbSelT wbSel,
	output isaPkg::regAddr rDst,
	output isaPkg::regAddr rSrc,
	output isaPkg::immVal immOut,
	output ctrlPkg::aluOpT aluOp
);

	import isaPkg::*;
	import ctrlPkg::*;

	seqStateT state;
	instWord inst;		// Latched instruction
	logic psrEn;
	condCode condSel;
	logic condTrue;

	fetchSequencer #(
		.acntWidth(acntWidth),
		.videoSlots(videoSlots)
	) u_seq (
		.clk(clk),
		.rst(rst),
		.instruction(instruction),
		.acnt(acnt),
		.state(state),
		.inst(inst)
	);

	instDecoder u_dec (
		.state(state),
		.inst(inst),
		.condTrue(condTrue),
		.branch(branch),
		.jump(jump),
		.memAddrSel(memAddrSel),
		.immSel(immSel),
		.pcEn(pcEn),
		.writeEn(writeEn),
		.sramCe(sramCe),
		.sramOe(sramOe),
		.sramWe(sramWe),
		.romCe(romCe),
		.romOe(romOe),
		.condResult(condResult),
		.wbSel(wbSel),
		.rDst(rDst),
		.rSrc(rSrc),
		.immOut(immOut),
		.aluOp(aluOp),
		.psrEn(psrEn),
		.condSel(condSel)
	);

	flagUnit u_flag (
		.clk(clk),
		.rst(rst),
		.psrIn(psrIn),
		.psrEn(psrEn),
		.condSel(condSel),
		.condTrue(condTrue)
	);

endmodule

//--- verif/cpuController_assertions.sv
module cpuControllerAssertions
#(
	parameter int acntWidth = 3,
	parameter int videoSlots = 2
)
(
	input logic clk,
	input logic rst,
	input isaPkg::instWord instruction,
	input isaPkg::psrWord psrIn,
	input logic [acntWidth-1:0] acnt,
	input logic branch,
	input logic jump,
	input logic memAddrSel,
	input logic immSel,
	input logic pcEn,
	input logic writeEn,
	input logic sramCe,
	input logic sramOe,
	input logic sramWe,
	input logic romCe,
	input logic romOe,
	input logic condResult,
	input ctrlPkg::wbSelT wbSel,
	input isaPkg::regAddr rDst,
	input isaPkg::regAddr rSrc,
	input isaPkg::immVal immOut,
	input ctrlPkg::aluOpT aluOp
);

	import isaPkg::*;
	import ctrlPkg::*;

	int failCount = 0;

	opCode op;
	extCode ext;
	logic isImm, isReg, isLoad, isStor, isJal, isJcond, isScond, isBcond, isKnown;
	logic settled;			// Out of reset for at least one edge
	logic romCePrev;
	logic [acntWidth-1:0] acntPrev;
	logic expectRomCe;
	psrWord shadowPsr;		// Flags as the ALU group last left them
	logic bcondHolds, jcondHolds;
	logic [9:0] resetActual;
	logic [18:0] immActual, immExpect;
	logic [13:0] regActual, regExpect;
	logic [2:0] condActual, condExpect;

	// Status table of the condition field
	function automatic logic condHolds(input psrWord psr, input condCode cc);
		case (cc)
			EQ: return psr[psrZ];
			CS: return psr[psrC];
			HI: return psr[psrL];
			GT: return psr[psrN];
			FS: return psr[psrF];
			NE: return !psr[psrZ];
			CC: return !psr[psrC];
			LS: return !psr[psrL];
			LE: return !psr[psrN];
			FC: return !psr[psrF];
			HS: return psr[psrZ] || psr[psrL];
			GE: return psr[psrZ] || psr[psrN];
			LO: return !(psr[psrZ] || psr[psrL]);
			LT: return !(psr[psrZ] || psr[psrN]);
			UC: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Register extensions reuse the immediate opcode numbering
	function automatic aluOpT aluOpFor(input opCode code);
		case (code)
			opAddui: return aluAddu;
			opSubi, opCmpi: return aluSub;
			opAndi: return aluAnd;
			opOri: return aluOr;
			opXori: return aluXor;
			opMovi: return aluMov;
			opLui: return aluLui;
			default: return aluAdd;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Instruction classes, from the held ROM word
	////////////////////////////////////////////////////////////////////////////

	assign op = instruction[15:12];
	assign ext = instruction[7:4];
	assign isImm = op inside {opAddi, opAddui, opSubi, opCmpi, opAndi, opOri, opXori,
		opMovi, opLui};
	assign isReg = (op == opRtype) && (ext inside {extAdd, extAddu, extSub, extCmp,
		extAnd, extOr, extXor, extMov});
	assign isLoad = (op == opOtype) && (ext == extLoad);
	assign isStor = (op == opOtype) && (ext == extStor);
	assign isJal = (op == opOtype) && (ext == extJal);
	assign isJcond = (op == opOtype) && (ext == extJcond);
	assign isScond = (op == opOtype) && (ext == extScond);
	assign isBcond = (op == opBcond);
	assign isKnown = isImm || isReg || isLoad || isStor || isJal || isJcond || isScond || isBcond;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			settled <= 1'b0;
			romCePrev <= 1'b0;
			acntPrev <= '0;
			shadowPsr <= '0;
		end
		else
		begin
			settled <= 1'b1;
			romCePrev <= romCe;
			acntPrev <= acnt;
			if (romCe && (isImm || isReg))
				shadowPsr <= psrIn;	// ALU decode updates the flags
		end
	end

	assign expectRomCe = (acntPrev < videoSlots) ? romCePrev : !romCePrev;

	// Branch and SCOND never take UC, JCOND does
	assign bcondHolds = condHolds(shadowPsr, instruction[3:0]) && (instruction[3:0] != UC);
	assign jcondHolds = condHolds(shadowPsr, instruction[11:8]);

	assign resetActual = {romCe, romOe, pcEn, writeEn, jump, branch, condResult,
		sramCe, sramOe, sramWe};
	assign immActual = {rDst, immOut, immSel, aluOp, writeEn, pcEn};
	assign immExpect = {instruction[11:8], instruction[7:0], 1'b1, aluOpFor(op),
		op != opCmpi, 1'b1};
	assign regActual = {rDst, rSrc, aluOp, writeEn, pcEn};
	assign regExpect = {instruction[11:8], instruction[3:0], aluOpFor(ext), ext != extCmp, 1'b1};
	assign condActual = {branch, jump, condResult};
	assign condExpect = {isBcond && bcondHolds, isJcond && jcondHolds, isScond && bcondHolds};

	////////////////////////////////////////////////////////////////////////////
	// Checks, decode is the romCe high phase
	////////////////////////////////////////////////////////////////////////////

	resetDefaults: assert property (@(posedge clk)
		(!rst || !settled) |-> (resetActual == 10'b0000000111))
	else
	begin
		failCount++;
		$error("Mismatch resetDefaults expected %b actual %b", 10'b0000000111,
			$sampled(resetActual));
	end

	arbiterHold: assert property (@(posedge clk) disable iff (!rst)
		settled |-> (romCe == expectRomCe))
	else
	begin
		failCount++;
		$error("Mismatch arbiterHold expected %b actual %b", $sampled(expectRomCe),
			$sampled(romCe));
	end

	aluImmDecode: assert property (@(posedge clk) disable iff (!rst)
		(romCe && isImm) |-> (immActual == immExpect))
	else
	begin
		failCount++;
		$error("Mismatch aluImmDecode expected %h actual %h", $sampled(immExpect),
			$sampled(immActual));
	end

	aluRegDecode: assert property (@(posedge clk) disable iff (!rst)
		(romCe && isReg) |-> (regActual == regExpect))
	else
	begin
		failCount++;
		$error("Mismatch aluRegDecode expected %h actual %h", $sampled(regExpect),
			$sampled(regActual));
	end

	condOutputs: assert property (@(posedge clk) disable iff (!rst)
		(romCe && (isBcond || isJcond || isScond)) |-> (condActual == condExpect))
	else
	begin
		failCount++;
		$error("Mismatch condOutputs expected %b actual %b", $sampled(condExpect),
			$sampled(condActual));
	end

	loadStrobes: assert property (@(posedge clk) disable iff (!rst)
		(romCe && isLoad) |->
		({sramCe, sramOe, sramWe, writeEn, memAddrSel, wbSel} == {5'b00111, memData}))
	else
	begin
		failCount++;
		$error("Mismatch loadStrobes expected %b actual %b", {5'b00111, memData},
			$sampled({sramCe, sramOe, sramWe, writeEn, memAddrSel, wbSel}));
	end

	storStrobes: assert property (@(posedge clk) disable iff (!rst)
		(romCe && isStor) |-> ({sramWe, writeEn, memAddrSel} == 3'b001))
	else
	begin
		failCount++;
		$error("Mismatch storStrobes expected %b actual %b", 3'b001,
			$sampled({sramWe, writeEn, memAddrSel}));
	end

	jalLink: assert property (@(posedge clk) disable iff (!rst)
		(romCe && isJal) |-> ({jump, rDst, wbSel} == {1'b1, 4'd15, linkPc}))
	else
	begin
		failCount++;
		$error("Mismatch jalLink expected %h actual %h", {1'b1, 4'd15, linkPc},
			$sampled({jump, rDst, wbSel}));
	end

	unknownDefaults: assert property (@(posedge clk) disable iff (!rst)
		(romCe && !isKnown) |-> ({pcEn, writeEn, sramCe, sramOe, sramWe} == 5'b00111))
	else
	begin
		failCount++;
		$error("Mismatch unknownDefaults expected %b actual %b", 5'b00111,
			$sampled({pcEn, writeEn, sramCe, sramOe, sramWe}));
	end

endmodule

bind cpuController cpuControllerAssertions #(
	.acntWidth(acntWidth),
	.videoSlots(videoSlots)
) u_chk (.*);

//--- verif/cpuControllerTb.sv
module cpuControllerTb;

	import isaPkg::*;
	import ctrlPkg::*;

	localparam int acntWidth = 3;
	localparam int videoSlots = 2;
	localparam int clkPeriod = 40;
	localparam int randomCount = 300;

	logic clk;
	logic rst;
	instWord instruction;
	psrWord psrIn;
	logic [acntWidth-1:0] acnt;
	logic branch, jump, memAddrSel, immSel, pcEn, writeEn;
	logic sramCe, sramOe, sramWe, romCe, romOe, condResult;
	wbSelT wbSel;
	regAddr rDst;
	regAddr rSrc;
	immVal immOut;
	aluOpT aluOp;

	logic [15:0] lfsrState;
	instWord progInst[$];
	psrWord progPsr[$];
	int watchdogCycles;

	cpuController #(
		.acntWidth(acntWidth),
		.videoSlots(videoSlots)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.instruction(instruction),
		.psrIn(psrIn),
		.acnt(acnt),
		.branch(branch),
		.jump(jump),
		.memAddrSel(memAddrSel),
		.immSel(immSel),
		.pcEn(pcEn),
		.writeEn(writeEn),
		.sramCe(sramCe),
		.sramOe(sramOe),
		.sramWe(sramWe),
		.romCe(romCe),
		.romOe(romOe),
		.condResult(condResult),
		.wbSel(wbSel),
		.rDst(rDst),
		.rSrc(rSrc),
		.immOut(immOut),
		.aluOp(aluOp)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// 16 bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] randBits(input int count);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[14:0], lfsrState[0]};
		end
		return value;
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	// Each instruction gets its own ALU status word
	task automatic addInst(input instWord word);
		logic [15:0] s;
		s = randBits(psrWidth);
		progInst.push_back(word);
		progPsr.push_back(s[psrWidth-1:0]);
	endtask

	task automatic buildProgram();
		opCode immOps[9];
		extCode regExts[8];
		extCode otherExts[5];
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] c;
		immOps = '{opAddi, opAddui, opSubi, opCmpi, opAndi, opOri, opXori, opMovi, opLui};
		regExts = '{extAdd, extAddu, extSub, extCmp, extAnd, extOr, extXor, extMov};
		otherExts = '{extLoad, extStor, extJal, extJcond, extScond};

		foreach (immOps[i])
		begin
			a = randBits(12);
			addInst({immOps[i], a[11:0]});
		end
		foreach (regExts[i])
		begin
			a = randBits(8);
			addInst({opRtype, a[7:4], regExts[i], a[3:0]});
		end
		foreach (otherExts[i])
		begin
			a = randBits(8);
			addInst({opOtype, a[7:4], otherExts[i], a[3:0]});
		end
		a = randBits(12);
		addInst({opBcond, a[11:0]});

		// Fresh flags before each condition code
		for (int cc = 0; cc < 16; cc++)
		begin
			a = randBits(12);
			addInst({opAddi, a[11:0]});
			a = randBits(8);
			addInst({opBcond, a[7:0], cc[3:0]});
			addInst({opOtype, cc[3:0], extJcond, a[3:0]});
			addInst({opOtype, a[7:4], extScond, cc[3:0]});
		end

		a = randBits(12);
		addInst({4'b0111, a[11:0]});	// Unused opcodes
		addInst({4'b1000, a[11:0]});
		addInst({opRtype, a[11:8], 4'b0000, a[3:0]});
		addInst({opOtype, a[11:8], 4'b1111, a[3:0]});

		repeat (randomCount)
		begin
			a = randBits(2);
			b = randBits(12);
			case (a[1:0])
				2'd0:
				begin
					c = randBits(4);
					addInst({c[3:0], b[11:0]});	// Any encoding at all
				end
				2'd1:
				begin
					c = randBits(4);
					addInst({immOps[c[3:0] % 9], b[11:0]});
				end
				2'd2: addInst({opRtype, b[11:0]});
				default:
				begin
					c = randBits(3);
					if (c[2:0] < 3'd5)
						addInst({opOtype, b[11:8], otherExts[c[2:0]], b[3:0]});
					else
						addInst({opBcond, b[11:0]});
				end
			endcase
		end
	endtask

	// Enters at a falling edge in fetch, leaves at the next fetch
	task automatic runInstruction(input instWord word, input psrWord status);
		logic sawDecode;
		logic [15:0] bits;
		sawDecode = 1'b0;
		instruction = word;
		psrIn = status;
		while (!sawDecode || romCe)
		begin
			bits = randBits(acntWidth);
			acnt = bits[acntWidth-1:0];
			@(negedge clk);
			if (romCe)
				sawDecode = 1'b1;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b0;
		instruction = '0;
		psrIn = '0;
		acnt = '0;
		lfsrState = 16'd3373;
		buildProgram();
		watchdogCycles = progInst.size() * 12 + 20;
		fork
			begin
				#(watchdogCycles * clkPeriod);
				abortRun("Watchdog timeout, the program did not finish in time");
			end
		join_none

		repeat (3) @(negedge clk);
		rst = 1'b1;
		foreach (progInst[i])
			runInstruction(progInst[i], progPsr[i]);
		@(negedge clk);

		if (u_dut.u_chk.failCount == 0)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
			abortRun("The checker reported failed assertions");
	end

	// Stops at the first failed assertion
	initial
	begin
		while (u_dut.u_chk.failCount == 0)
			@(negedge clk);
		abortRun("An assertion in the checker failed");
	end

endmodule

//--- all.f
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/fetchSequencer.sv
logic/instDecoder.sv
logic/flagUnit.sv
logic/cpuController.sv
verif/cpuController_assertions.sv
verif/cpuControllerTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module cpuControllerTb -Mdir obj_dir -f all.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

# Keep running past an assertion so the testbench can stop the run itself
./obj_dir/VcpuControllerTb +verilator+error+limit+1000
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
